// File: project.f
hw/racePkg.sv
hw/rasterScanner.sv
hw/memoryAddresser.sv
hw/pixelCompositor.sv
hw/carMotion.sv
hw/lapMonitor.sv
hw/raceDatapath.sv
dv/clockGen.sv
dv/raceTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the race datapath testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module raceTb -f project.f -o raceSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/raceSim > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -qx "all tests passed" "$LOG"; then
	exit 0
fi
echo "Pass line not found in $LOG"
exit 1

// File: dv/raceTb.sv
`timescale 1ns/100ps
`default_nettype none

module raceTb import racePkg::*; ();

	typedef enum int {stepForward, turnRight, turnLeft} moveKind_e;

	logic Clock;
	logic set_reset_signals;
	logic startRace;
	logic drawBackground;
	logic drawCar;
	logic move;
	logic moveForward;
	logic moveRight;
	logic moveLeft;
	logic [colourWidth-1:0] trackColour = '0;
	logic [colourWidth-1:0] spriteColour = '0;
	logic [trackAddrWidth-1:0] trackAddress;
	logic [spriteAddrWidth-1:0] spriteAddress;
	logic pixelValid, DoneDrawBackground, DoneDrawCar, HitWall, FinishedRace;
	logic [xWidth-1:0] xOut;
	logic [yWidth-1:0] yOut;
	logic [colourWidth-1:0] colourOut;

	logic [xWidth+yWidth+colourWidth-1:0] expectQ[$]; // Predicted pixels in emit order
	logic [xWidth-1:0] expX;
	logic [yWidth-1:0] expY;
	logic [colourWidth-1:0] expColour;
	// Forward step per heading, screen y grows downward
	int dxTable[16] = '{2, 2, 2, 1, 0, -1, -2, -2, -2, -2, -2, -1, 0, 1, 2, 2};
	int dyTable[16] = '{0, -1, -2, -2, -2, -2, -2, -1, 0, 1, 2, 2, 2, 2, 2, 1};
	int refHeading, refX, refY;
	int errorCount, checkCount, pixelCount, testErrors, testCount;
	int randomMoves = 24;
	logic [31:0] lfsrState = 32'ha5a4;

	clockGen i_clockGen (.Clock, .set_reset_signals);

	raceDatapath i_dut (.*);

	// Grass outside the open rectangle, checkered tarmac inside
	function automatic logic [colourWidth-1:0] trackColourAt(input int x, input int y);
		logic [colourWidth-1:0] mix;
		if (y < 150 || y > 232 || x < 100 || x > 220)
			return wallColour;
		mix = colourWidth'((y % 8) * 8 + x % 8);
		return (mix == wallColour) ? 6'h3f : mix;
	endfunction

	function automatic logic [colourWidth-1:0] spriteColourAt(input int h, input int row,
			input int col);
		logic [colourWidth-1:0] tint;
		if (row < 8 || row > 23 || col < 8 || col > 23)
			return transparentColour; // Only the central 16x16 block is opaque
		tint = colourWidth'(h * 4 + row % 4 + col % 4);
		return (tint == transparentColour) ? 6'h01 : tint;
	endfunction

	// ROMs answer one cycle after the address
	always @(posedge Clock) begin
		trackColour <= trackColourAt(int'(trackAddress) % screenWidth,
			int'(trackAddress) / screenWidth);
		spriteColour <= spriteColourAt(spriteAddress[13:10], spriteAddress[9:5],
			spriteAddress[4:0]);
	end

	function automatic logic [31:0] galoisStep(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hd0000001) : (s >> 1);
	endfunction

	function automatic int randomBits(input int count);
		int value;
		int i;
		value = 0;
		for (i = 0; i < count; i++) begin
			value = (value << 1) | int'(lfsrState[0]);
			lfsrState = galoisStep(lfsrState);
		end
		return value;
	endfunction

	// Expected screen position and colour of one scan pixel, and whether it hits a wall
	function automatic bit expectedPixel(input bit car, input int sx, input int sy,
			output int x, output int y, output logic [colourWidth-1:0] colour);
		logic [colourWidth-1:0] track;
		logic [colourWidth-1:0] sprite;
		x = car ? refX + sx : sx;
		y = car ? refY + sy : sy;
		track = trackColourAt(x, y);
		sprite = car ? spriteColourAt(refHeading, sy, sx) : transparentColour;
		colour = (sprite == transparentColour) ? track : sprite;
		return sprite != transparentColour && track == wallColour;
	endfunction

	function automatic bit forwardStaysOpen();
		int nx;
		int ny;
		nx = refX + dxTable[refHeading];
		ny = refY + dyTable[refHeading];
		// Opaque block covers offsets 8 to 23
		return nx + 8 >= 100 && nx + 23 <= 220 && ny + 8 >= 150 && ny + 23 <= 232;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] got,
			input logic [31:0] want);
		checkCount++;
		if (got !== want) begin
			$display("Mismatch %s: got %h, expected %h", name, got, want);
			errorCount++;
		end
	endtask

	always @(negedge Clock) begin
		if (pixelValid === 1'b1) begin
			pixelCount++;
			if (expectQ.size() == 0) begin
				$display("Pixel at (%0d, %0d) arrived when none was expected", xOut, yOut);
				errorCount++;
			end else begin
				{expX, expY, expColour} = expectQ.pop_front();
				checkValue("xOut", 32'(xOut), 32'(expX));
				checkValue("yOut", 32'(yOut), 32'(expY));
				checkValue("colourOut", 32'(colourOut), 32'(expColour));
			end
		end
	end

	task automatic drawAndCheck(input bit car);
		int rows, cols, sx, sy, x, y, waited;
		logic [colourWidth-1:0] colour;
		bit hitExpected;
		cols = car ? spriteSize : screenWidth;
		rows = car ? spriteSize : screenHeight;
		hitExpected = 1'b0;
		for (sy = 0; sy < rows && !hitExpected; sy++)
			for (sx = 0; sx < cols && !hitExpected; sx++) begin
				hitExpected = expectedPixel(car, sx, sy, x, y, colour);
				expectQ.push_back({xWidth'(x), yWidth'(y), colour});
			end
		drawCar = car;
		drawBackground = !car;
		waited = 0;
		while ((car ? DoneDrawCar : DoneDrawBackground) !== 1'b1 && waited < rows * cols + 8) begin
			@(negedge Clock);
			waited++;
		end
		if (waited >= rows * cols + 8) begin
			$display("The %s draw never raised its done flag", car ? "car" : "background");
			errorCount++;
		end
		drawCar = 1'b0;
		drawBackground = 1'b0;
		repeat (4) @(negedge Clock); // Stray pixels after done show up here
		checkValue("pendingPixels", expectQ.size(), 0);
		expectQ.delete();
		if (car)
			checkValue("HitWall", 32'(HitWall), 32'(hitExpected));
	endtask

	task automatic issueMove(input moveKind_e kind);
		move = 1'b1;
		moveForward = (kind == stepForward);
		moveRight = (kind == turnRight);
		moveLeft = (kind == turnLeft);
		@(negedge Clock);
		move = 1'b0;
		@(negedge Clock); // Lap flags trail the position by a cycle
		if (kind == stepForward) begin
			refX = refX + dxTable[refHeading];
			refY = refY + dyTable[refHeading];
		end else if (kind == turnRight) begin
			refHeading = (refHeading + 15) % 16;
		end else begin
			refHeading = (refHeading + 1) % 16;
		end
	endtask

	task automatic endTest(input string name);
		testCount++;
		$display("%s: %0d errors", name, errorCount - testErrors);
		testErrors = errorCount;
	endtask

	initial begin
		int pick;
		int step;
		startRace = 1'b0;
		drawBackground = 1'b0;
		drawCar = 1'b0;
		move = 1'b0;
		moveForward = 1'b0;
		moveRight = 1'b0;
		moveLeft = 1'b0;
		refHeading = headingRight;
		refX = startX;
		refY = startY;
		wait (set_reset_signals === 1'b0);
		@(negedge Clock);

		checkValue("FinishedRace", 32'(FinishedRace), 1);
		checkValue("DoneDrawBackground", 32'(DoneDrawBackground), 0);
		checkValue("DoneDrawCar", 32'(DoneDrawCar), 0);
		checkValue("HitWall", 32'(HitWall), 0);
		drawAndCheck(1'b0);
		checkValue("DoneDrawBackground", 32'(DoneDrawBackground), 1);
		endTest("reset state and background");

		drawAndCheck(1'b1);
		checkValue("DoneDrawCar", 32'(DoneDrawCar), 1);
		endTest("car at start");

		startRace = 1'b1;
		@(negedge Clock);
		startRace = 1'b0;
		@(negedge Clock);
		checkValue("FinishedRace", 32'(FinishedRace), 0);
		for (step = 1; step <= 19; step++) begin
			issueMove(stepForward); // Out past the start line at x=164
			checkValue("FinishedRace", 32'(FinishedRace), 0);
		end
		repeat (8) issueMove(turnLeft);
		for (step = 1; step <= 19; step++) begin
			issueMove(stepForward);
			checkValue("FinishedRace", 32'(FinishedRace), 32'(step == 19));
		end
		drawAndCheck(1'b1);
		endTest("lap");

		for (step = 0; step < randomMoves; step++) begin
			pick = randomBits(2);
			if (pick < 2 && forwardStaysOpen())
				issueMove(stepForward);
			else if (pick == 2)
				issueMove(turnRight);
			else
				issueMove(turnLeft); // Also taken when forward would reach grass
			drawAndCheck(1'b1);
		end
		endTest("steering and stepping");

		while (refHeading != headingUp)
			issueMove(turnLeft);
		while (refY + 8 >= 150)
			issueMove(stepForward);
		drawAndCheck(1'b1);
		checkValue("HitWall", 32'(HitWall), 1);
		checkValue("DoneDrawCar", 32'(DoneDrawCar), 1);
		issueMove(turnRight);
		checkValue("HitWall", 32'(HitWall), 1);
		checkValue("DoneDrawCar", 32'(DoneDrawCar), 0);
		endTest("wall hit");

		$display("%0d tests, %0d checks, %0d pixels, %0d errors", testCount, checkCount,
			pixelCount, errorCount);
		if (errorCount == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	initial begin
		int cycles;
		cycles = screenWidth * screenHeight + (randomMoves + 3) * spriteSize * spriteSize + 4000;
		#(cycles * 20);
		$display("Watchdog expired after %0d cycles before the run ended", cycles);
		$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/clockGen.sv
`timescale 1ns/100ps
`default_nettype none

module clockGen (
	output logic Clock,
	output logic set_reset_signals
);

	initial begin
		Clock = 1'b0;
		forever #10 Clock = ~Clock; // 20 ns period
	end

	// Reset spans three rising edges and drops on a falling edge
	initial begin
		set_reset_signals = 1'b1;
		repeat (3) @(posedge Clock);
		@(negedge Clock);
		set_reset_signals = 1'b0;
	end

endmodule

`default_nettype wire

// File: hw/raceDatapath.sv
`timescale 1ns/100ps
`default_nettype none

module raceDatapath import racePkg::*; (
	input  logic                       Clock,
	input  logic                       set_reset_signals,
	input  logic                       startRace,
	input  logic                       drawBackground,
	input  logic                       drawCar,
	input  logic                       move,
	input  logic                       moveForward,
	input  logic                       moveRight,
	input  logic                       moveLeft,
	input  logic [colourWidth-1:0]     trackColour,
	input  logic [colourWidth-1:0]     spriteColour,
	output logic [trackAddrWidth-1:0]  trackAddress,
	output logic [spriteAddrWidth-1:0] spriteAddress,
	output logic                       pixelValid,
	output logic [xWidth-1:0]          xOut,
	output logic [yWidth-1:0]          yOut,
	output logic [colourWidth-1:0]     colourOut,
	output logic                       DoneDrawBackground,
	output logic                       DoneDrawCar,
	output logic                       HitWall,
	output logic                       FinishedRace
);

	logic scanValid, scanCar, scanLast;
	logic [xWidth-1:0] scanX;
	logic [yWidth-1:0] scanY;
	logic addrValid, addrCar, addrLast;
	logic [xWidth-1:0] addrX;
	logic [yWidth-1:0] addrY;
	logic abort;
	logic [headingWidth-1:0] heading;
	logic [xWidth-1:0] carX;
	logic [yWidth-1:0] carY;

	rasterScanner i_rasterScanner (
		.Clock, .set_reset_signals, .drawBackground, .drawCar, .move, .abort,
		.scanValid, .scanX, .scanY, .scanCar, .scanLast
	);

	// Addresses go straight out to the track and sprite ROMs
	memoryAddresser i_memoryAddresser (
		.Clock, .set_reset_signals, .scanValid, .scanX, .scanY, .scanCar, .scanLast,
		.carX, .carY, .heading, .trackAddress, .spriteAddress,
		.addrValid, .addrX, .addrY, .addrCar, .addrLast
	);

	pixelCompositor i_pixelCompositor (
		.Clock, .set_reset_signals, .move, .addrValid, .addrX, .addrY, .addrCar, .addrLast,
		.trackColour, .spriteColour, .abort, .pixelValid, .xOut, .yOut, .colourOut,
		.DoneDrawBackground, .DoneDrawCar, .HitWall
	);

	carMotion i_carMotion (
		.Clock, .set_reset_signals, .move, .moveForward, .moveRight, .moveLeft,
		.heading, .carX, .carY
	);

	lapMonitor i_lapMonitor (
		.Clock, .set_reset_signals, .startRace, .carX, .carY, .FinishedRace
	);

endmodule

`default_nettype wire

// File: hw/lapMonitor.sv
`timescale 1ns/100ps
`default_nettype none

module lapMonitor import racePkg::*; (
	input  logic              Clock,
	input  logic              set_reset_signals,
	input  logic              startRace,
	input  logic [xWidth-1:0] carX,
	input  logic [yWidth-1:0] carY,
	output logic              FinishedRace
);

	logic inBand;
	logic onStartLine;
	logic onFinishLine;
	logic passedStart;

	assign inBand = (carY >= yWidth'(lineYLow)) && (carY <= yWidth'(lineYHigh));
	assign onStartLine = inBand && (carX == xWidth'(startLineX));
	assign onFinishLine = inBand && (carX == xWidth'(finishLineX));

	always_ff @(posedge Clock) begin
		if (set_reset_signals) begin
			FinishedRace <= 1'b1; // Idle until a race is started
			passedStart <= 1'b0;
		end else if (startRace) begin
			FinishedRace <= 1'b0;
			passedStart <= 1'b0;
		end else begin
			if (onStartLine)
				passedStart <= 1'b1;
			// Finish only counts once the start line is behind the car
			if (!FinishedRace && passedStart && onFinishLine)
				FinishedRace <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: hw/carMotion.sv
`timescale 1ns/100ps
`default_nettype none

module carMotion import racePkg::*; (
	input  logic                    Clock,
	input  logic                    set_reset_signals,
	input  logic                    move,
	input  logic                    moveForward,
	input  logic                    moveRight,
	input  logic                    moveLeft,
	output logic [headingWidth-1:0] heading,
	output logic [xWidth-1:0]       carX,
	output logic [yWidth-1:0]       carY
);

	int dx;
	int dy;
	logic [xWidth-1:0] stepX;
	logic [yWidth-1:0] stepY;

	// Two's complement steps, screen y grows downward
	always_comb begin
		case (heading)
			headingRight:          begin dx = pixelsToMove;      dy = 0;                 end
			headingUpRightRight:   begin dx = pixelsToMove;      dy = 1 - pixelsToMove;  end
			headingUpRight:        begin dx = pixelsToMove;      dy = -pixelsToMove;     end
			headingUpUpRight:      begin dx = pixelsToMove - 1;  dy = -pixelsToMove;     end
			headingUp:             begin dx = 0;                 dy = -pixelsToMove;     end
			headingUpUpLeft:       begin dx = 1 - pixelsToMove;  dy = -pixelsToMove;     end
			headingUpLeft:         begin dx = -pixelsToMove;     dy = -pixelsToMove;     end
			headingUpLeftLeft:     begin dx = -pixelsToMove;     dy = 1 - pixelsToMove;  end
			headingLeft:           begin dx = -pixelsToMove;     dy = 0;                 end
			headingDownLeftLeft:   begin dx = -pixelsToMove;     dy = pixelsToMove - 1;  end
			headingDownLeft:       begin dx = -pixelsToMove;     dy = pixelsToMove;      end
			headingDownDownLeft:   begin dx = 1 - pixelsToMove;  dy = pixelsToMove;      end
			headingDown:           begin dx = 0;                 dy = pixelsToMove;      end
			headingDownDownRight:  begin dx = pixelsToMove - 1;  dy = pixelsToMove;      end
			headingDownRight:      begin dx = pixelsToMove;      dy = pixelsToMove;      end
			default:               begin dx = pixelsToMove;      dy = pixelsToMove - 1;  end
		endcase
		stepX = xWidth'(dx);
		stepY = yWidth'(dy);
	end

	always_ff @(posedge Clock) begin
		if (set_reset_signals) begin
			heading <= headingRight;
			carX <= xWidth'(startX);
			carY <= yWidth'(startY);
		end else if (move) begin
			if (moveForward) begin
				carX <= carX + stepX;
				carY <= carY + stepY;
			end else if (moveRight) begin
				heading <= heading - 1'b1; // Clockwise, wraps at 16
			end else if (moveLeft) begin
				heading <= heading + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/pixelCompositor.sv
`timescale 1ns/100ps
`default_nettype none

module pixelCompositor import racePkg::*; (
	input  logic                   Clock,
	input  logic                   set_reset_signals,
	input  logic                   move,
	input  logic                   addrValid,
	input  logic [xWidth-1:0]      addrX,
	input  logic [yWidth-1:0]      addrY,
	input  logic                   addrCar,
	input  logic                   addrLast,
	input  logic [colourWidth-1:0] trackColour,
	input  logic [colourWidth-1:0] spriteColour,
	output logic                   abort,
	output logic                   pixelValid,
	output logic [xWidth-1:0]      xOut,
	output logic [yWidth-1:0]      yOut,
	output logic [colourWidth-1:0] colourOut,
	output logic                   DoneDrawBackground,
	output logic                   DoneDrawCar,
	output logic                   HitWall
);

	logic opaque;
	logic wallHit;
	logic pixelLast;
	logic pixelCar;

	assign opaque = (spriteColour != transparentColour);
	// First opaque car pixel over grass ends the draw
	assign wallHit = addrValid && addrCar && !abort && opaque && (trackColour == wallColour);

	always_ff @(posedge Clock) begin
		if (set_reset_signals) begin
			pixelValid <= 1'b0;
			abort <= 1'b0;
			DoneDrawBackground <= 1'b0;
			DoneDrawCar <= 1'b0;
			HitWall <= 1'b0;
		end else begin
			pixelValid <= addrValid && !(addrCar && abort); // Drop car pixels after a hit
			if (wallHit)
				abort <= 1'b1;
			else if (move)
				abort <= 1'b0;
			if (move) begin
				DoneDrawBackground <= 1'b0;
				DoneDrawCar <= 1'b0;
			end else begin
				if (pixelValid && pixelLast && !pixelCar)
					DoneDrawBackground <= 1'b1;
				if ((pixelValid && pixelLast && pixelCar) || abort)
					DoneDrawCar <= 1'b1;
			end
			if (abort)
				HitWall <= 1'b1; // Sticky until reset
		end
	end

	always_ff @(posedge Clock) begin
		xOut <= addrX;
		yOut <= addrY;
		colourOut <= (addrCar && opaque) ? spriteColour : trackColour;
		pixelLast <= addrLast;
		pixelCar <= addrCar;
	end

endmodule

`default_nettype wire

// File: hw/memoryAddresser.sv
`timescale 1ns/100ps
`default_nettype none

module memoryAddresser import racePkg::*; (
	input  logic                       Clock,
	input  logic                       set_reset_signals,
	input  logic                       scanValid,
	input  logic [xWidth-1:0]          scanX,
	input  logic [yWidth-1:0]          scanY,
	input  logic                       scanCar,
	input  logic                       scanLast,
	input  logic [xWidth-1:0]          carX,
	input  logic [yWidth-1:0]          carY,
	input  logic [headingWidth-1:0]    heading,
	output logic [trackAddrWidth-1:0]  trackAddress,
	output logic [spriteAddrWidth-1:0] spriteAddress,
	output logic                       addrValid,
	output logic [xWidth-1:0]          addrX,
	output logic [yWidth-1:0]          addrY,
	output logic                       addrCar,
	output logic                       addrLast
);

	logic [xWidth-1:0] screenX;
	logic [yWidth-1:0] screenY;
	logic [trackAddrWidth-1:0] rowBase;
	spriteAddr_u spriteWord;

	// Car pixels are relative to the car's top-left corner
	assign screenX = scanCar ? scanX + carX : scanX;
	assign screenY = scanCar ? scanY + carY : scanY;

	// y*320 as y*256 + y*64
	assign rowBase = (trackAddrWidth'(screenY) << 8) + (trackAddrWidth'(screenY) << 6);
	assign trackAddress = rowBase + trackAddrWidth'(screenX);

	always_comb begin
		spriteWord.field.heading = heading;
		spriteWord.field.row = scanY[spriteIndexWidth-1:0];
		spriteWord.field.column = scanX[spriteIndexWidth-1:0];
	end
	assign spriteAddress = spriteWord.flat;

	// Tags line up with the ROM data one cycle later
	always_ff @(posedge Clock) begin
		if (set_reset_signals)
			addrValid <= 1'b0;
		else
			addrValid <= scanValid;
		addrX <= screenX;
		addrY <= screenY;
		addrCar <= scanCar;
		addrLast <= scanLast;
	end

endmodule

`default_nettype wire

// File: hw/rasterScanner.sv
`timescale 1ns/100ps
`default_nettype none

module rasterScanner import racePkg::*; (
	input  logic              Clock,
	input  logic              set_reset_signals,
	input  logic              drawBackground,
	input  logic              drawCar,
	input  logic              move,
	input  logic              abort,
	output logic              scanValid,
	output logic [xWidth-1:0] scanX,
	output logic [yWidth-1:0] scanY,
	output logic              scanCar,
	output logic              scanLast
);

	logic [xWidth-1:0] xCount;
	logic [yWidth-1:0] yCount;
	logic [xWidth-1:0] xMax;
	logic [yWidth-1:0] yMax;
	logic finishedBackground;
	logic finishedCar;
	logic scanBackground;
	logic scanSprite;
	logic endOfRow;
	logic lastPixel;

	// Background has priority over the car square
	assign scanBackground = drawBackground && !finishedBackground;
	assign scanSprite = !scanBackground && drawCar && !finishedCar;

	assign xMax = scanBackground ? xWidth'(screenWidth - 1) : xWidth'(spriteSize - 1);
	assign yMax = scanBackground ? yWidth'(screenHeight - 1) : yWidth'(spriteSize - 1);
	assign endOfRow = (xCount == xMax);
	assign lastPixel = endOfRow && (yCount == yMax);

	always_ff @(posedge Clock) begin
		if (set_reset_signals) begin
			scanValid <= 1'b0;
			xCount <= '0;
			yCount <= '0;
			finishedBackground <= 1'b0;
			finishedCar <= 1'b0;
		end else begin
			scanValid <= 1'b0;
			if (move) begin
				finishedBackground <= 1'b0;
				finishedCar <= 1'b0;
			end
			if (scanSprite && abort) begin // Wall hit downstream
				finishedCar <= 1'b1;
				xCount <= '0;
				yCount <= '0;
			end else if (scanBackground || scanSprite) begin
				scanValid <= 1'b1;
				scanX <= xCount;
				scanY <= yCount;
				scanCar <= scanSprite;
				scanLast <= lastPixel;
				if (lastPixel) begin
					xCount <= '0;
					yCount <= '0;
					if (scanBackground)
						finishedBackground <= 1'b1;
					else
						finishedCar <= 1'b1;
				end else if (endOfRow) begin
					xCount <= '0;
					yCount <= yCount + 1'b1;
				end else begin
					xCount <= xCount + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/racePkg.sv
`default_nettype none

package racePkg;

	// Screen and track geometry
	localparam int screenWidth = 320;
	localparam int screenHeight = 240;
	localparam int xWidth = 9;
	localparam int yWidth = 8;
	localparam int trackAddrWidth = 17;

	// Sprite atlas, one 32x32 square per heading
	localparam int spriteSize = 32;
	localparam int spriteIndexWidth = 5;
	localparam int headingWidth = 4;
	localparam int spriteAddrWidth = 14;

	localparam int colourWidth = 6;
	localparam logic [colourWidth-1:0] transparentColour = 6'b100010; // Purple key
	localparam logic [colourWidth-1:0] wallColour = 6'b001100;        // Grass green

	// Motion and race geometry
	localparam int pixelsToMove = 2;
	localparam int startX = 126;
	localparam int startY = 197;
	localparam int startLineX = 164;
	localparam int finishLineX = 126;
	localparam int lineYLow = 184;  // Band is inclusive at both ends
	localparam int lineYHigh = 205;

	// Headings, counter-clockwise from right in 22.5 degree steps
	localparam logic [headingWidth-1:0] headingRight = 4'd0;
	localparam logic [headingWidth-1:0] headingUpRightRight = 4'd1;
	localparam logic [headingWidth-1:0] headingUpRight = 4'd2;
	localparam logic [headingWidth-1:0] headingUpUpRight = 4'd3;
	localparam logic [headingWidth-1:0] headingUp = 4'd4;
	localparam logic [headingWidth-1:0] headingUpUpLeft = 4'd5;
	localparam logic [headingWidth-1:0] headingUpLeft = 4'd6;
	localparam logic [headingWidth-1:0] headingUpLeftLeft = 4'd7;
	localparam logic [headingWidth-1:0] headingLeft = 4'd8;
	localparam logic [headingWidth-1:0] headingDownLeftLeft = 4'd9;
	localparam logic [headingWidth-1:0] headingDownLeft = 4'd10;
	localparam logic [headingWidth-1:0] headingDownDownLeft = 4'd11;
	localparam logic [headingWidth-1:0] headingDown = 4'd12;
	localparam logic [headingWidth-1:0] headingDownDownRight = 4'd13;
	localparam logic [headingWidth-1:0] headingDownRight = 4'd14;
	localparam logic [headingWidth-1:0] headingDownRightRight = 4'd15;

	// Sprite ROM word, flat address or heading/row/column
	typedef union packed {
		logic [spriteAddrWidth-1:0] flat;
		struct packed {
			logic [headingWidth-1:0] heading;
			logic [spriteIndexWidth-1:0] row;
			logic [spriteIndexWidth-1:0] column;
		} field;
	} spriteAddr_u;

endpackage

`default_nettype wire
